//--- fetch_frontend.f
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_pc.sv
verilog/line_fetch.sv
verilog/fetch_queue.sv
verilog/fetch_frontend.sv
bench/bmem_model.sv
bench/fetch_frontend_tb.sv

//--- bench/fetch_frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_frontend_tb;

    import fetch_pkg::*;

    localparam logic [31:0] PATTERN = 32'ha5a5a5a5;
    localparam int MAX_GAP        = 3;
    localparam int LINE_BYTES     = `FETCH_BEAT_WIDTH / 8 * `FETCH_LINE_BEATS;
    localparam int MAX_BURST      = `FETCH_LINE_BEATS * (MAX_GAP + 1) + 2;
    localparam int SEQ_WORDS      = 40;
    localparam int REDIRECT_WORDS = 20;
    localparam int NUM_REDIRECTS  = 4;
    localparam int TOTAL_WORDS    = 3 * SEQ_WORDS + NUM_REDIRECTS * REDIRECT_WORDS;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_WORDS * MAX_BURST;

    logic        clk;
    logic        rst;
    logic        redirect;
    fetch_addr_t redirect_pc;
    logic        inst_avail;
    fetch_word_t inst_word;
    logic        inst_deq;
    fetch_addr_t bmem_addr;
    logic        bmem_read;
    logic        bmem_ready;
    beat_t       bmem_rdata;
    logic        bmem_rvalid;

    logic        consumer_on          = 1'b0;
    fetch_addr_t expected_pc          = `FETCH_RESET_PC;
    fetch_addr_t last_read_addr       = '0;
    int          delivered            = 0;
    int          beats_pending        = 0;
    int          reads_since_redirect = 1;   // no earlier read to compare with
    logic        read_prev            = 1'b0;
    logic        redirect_prev        = 1'b0;
    int          cycles               = 0;

    fetch_frontend dut (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .inst_avail_o  (inst_avail),
        .inst_o        (inst_word),
        .inst_deq_i    (inst_deq),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid)
    );

    bmem_model #(.PATTERN(PATTERN), .MAX_GAP(MAX_GAP)) mem (
        .clk      (clk),
        .rst      (rst),
        .addr_i   (bmem_addr),
        .read_i   (bmem_read),
        .ready_o  (bmem_ready),
        .rdata_o  (bmem_rdata),
        .rvalid_o (bmem_rvalid)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] want);
        abort_run($sformatf("mismatch %s: got %08h expected %08h", name, got, want));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_words(input int n);
        int target;
        target = delivered + n;
        while (delivered < target) begin
            idle_cycles(1);
        end
    endtask

    task automatic find_refill();
        idle_cycles(1);
        while (beats_pending == 0) begin
            idle_cycles(1);
        end
    endtask

    task automatic pulse_redirect();
        redirect    = 1'b1;
        redirect_pc = fetch_addr_t'($urandom) & ~fetch_addr_t'(3);  // word aligned
        idle_cycles(1);
        redirect    = 1'b0;
    endtask

    // consumer with a random dequeue pattern
    initial begin
        inst_deq = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            inst_deq = consumer_on ? 1'($urandom_range(1, 0)) : 1'b0;
        end
    end

    // monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (bmem_rvalid) begin
                beats_pending = beats_pending - 1;
            end
            if (bmem_read) begin
                assert (bmem_ready) else abort_run("read strobe raised while memory not ready");
                assert (!read_prev) else abort_run("read strobe held for more than one cycle");
                assert (beats_pending == 0)
                    else abort_run("new read issued before four beats returned");
                assert (bmem_addr % LINE_BYTES == 0)
                    else fail_value("bmem_addr_o offset", 32'(bmem_addr % LINE_BYTES), 32'd0);
                if (reads_since_redirect >= 2) begin
                    assert (bmem_addr == last_read_addr + fetch_addr_t'(LINE_BYTES))
                        else fail_value("bmem_addr_o", bmem_addr,
                                        last_read_addr + fetch_addr_t'(LINE_BYTES));
                end
                last_read_addr       = bmem_addr;
                beats_pending        = `FETCH_LINE_BEATS;
                reads_since_redirect = reads_since_redirect + 1;
            end
            read_prev = bmem_read;

            if (inst_avail && inst_deq) begin
                assert (inst_word.pc == expected_pc)
                    else fail_value("inst_o.pc", inst_word.pc, expected_pc);
                assert (inst_word.inst == (expected_pc ^ PATTERN))
                    else fail_value("inst_o.inst", inst_word.inst, expected_pc ^ PATTERN);
                expected_pc = expected_pc + 32'd4;
                delivered   = delivered + 1;
            end
            if (redirect_prev) begin
                assert (!inst_avail)
                    else abort_run("instructions still available after a redirect");
            end
            if (redirect) begin
                expected_pc          = redirect_pc;     // target is the next word
                reads_since_redirect = 0;
            end
            redirect_prev = redirect;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout after %0d cycles with %0d words delivered",
                                    cycles, delivered));
            end
        end
    end

    initial begin
        void'($urandom(32'h8b91e94f));
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        idle_cycles(10);
        rst = 1'b0;
        @(negedge clk);
        assert (!inst_avail) else abort_run("instructions available right after reset");
        assert (!bmem_read) else abort_run("read strobe high right after reset");
        idle_cycles(1);
        consumer_on <= 1'b1;

        wait_words(SEQ_WORDS);                          // sequential from reset PC

        consumer_on <= 1'b0;                            // long stall fills the queue
        idle_cycles(200);
        assert (dut.queue_i.count_q == `FETCH_QUEUE_DEPTH)
            else fail_value("queue occupancy", 32'(dut.queue_i.count_q), `FETCH_QUEUE_DEPTH);
        consumer_on <= 1'b1;
        wait_words(SEQ_WORDS);

        repeat (NUM_REDIRECTS) begin
            find_refill();                              // redirect mid-burst
            pulse_redirect();
            wait_words(REDIRECT_WORDS);
        end

        consumer_on <= 1'b0;
        idle_cycles(100);
        pulse_redirect();                               // redirect with queue full
        idle_cycles(150);
        assert (dut.queue_i.count_q == `FETCH_QUEUE_DEPTH)
            else fail_value("queue occupancy", 32'(dut.queue_i.count_q), `FETCH_QUEUE_DEPTH);
        consumer_on <= 1'b1;
        wait_words(SEQ_WORDS);

        idle_cycles(5);
        $display("All tests passed!");
        $finish;
    end

endmodule : fetch_frontend_tb

`default_nettype wire

//--- bench/bmem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module bmem_model #(
    parameter logic [31:0] PATTERN = 32'ha5a5a5a5,
    parameter int          MAX_GAP = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::fetch_addr_t addr_i,
    input  logic                   read_i,
    output logic                   ready_o,
    output fetch_pkg::beat_t       rdata_o,
    output logic                   rvalid_o
);

    import fetch_pkg::*;

    logic        busy;
    logic        read_seen;
    fetch_addr_t read_addr;
    fetch_addr_t base;
    int          beat;
    int          gap;

    // every 32-bit word holds its own address scrambled by the pattern
    function automatic beat_t beat_data(input fetch_addr_t line_base, input int idx);
        fetch_addr_t lo_addr;
        lo_addr   = line_base + fetch_addr_t'(idx * (`FETCH_BEAT_WIDTH / 8));
        beat_data = {(lo_addr + 32'd4) ^ PATTERN, lo_addr ^ PATTERN};  // lower address low
    endfunction

    initial begin
        ready_o  = 1'b0;
        rvalid_o = 1'b0;
        rdata_o  = '0;
        busy     = 1'b0;
        forever begin
            @(negedge clk);
            read_seen = read_i;                         // stable at mid-cycle
            read_addr = addr_i;
            @(posedge clk);
            #1;
            rvalid_o = 1'b0;
            if (rst) begin
                busy = 1'b0;
            end else if (read_seen) begin
                busy = 1'b1;                            // burst starts next cycle
                base = read_addr;
                beat = 0;
                gap  = $urandom_range(MAX_GAP, 0);
            end else if (busy) begin
                if (gap == 0) begin
                    rvalid_o = 1'b1;
                    rdata_o  = beat_data(base, beat);
                    beat     = beat + 1;
                    busy     = (beat < `FETCH_LINE_BEATS);
                    gap      = $urandom_range(MAX_GAP, 0);
                end else begin
                    gap = gap - 1;
                end
            end
            ready_o = ($urandom_range(3, 0) != 0);      // ready about 3 cycles in 4
        end
    end

endmodule : bmem_model

`default_nettype wire

//--- verilog/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_frontend (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   redirect_i,
    input  fetch_pkg::fetch_addr_t redirect_pc_i,

    output logic                   inst_avail_o,
    output fetch_pkg::fetch_word_t inst_o,
    input  logic                   inst_deq_i,

    output fetch_pkg::fetch_addr_t bmem_addr_o,
    output logic                   bmem_read_o,
    input  logic                   bmem_ready_i,
    input  fetch_pkg::beat_t       bmem_rdata_i,
    input  logic                   bmem_rvalid_i
);

    import fetch_pkg::*;

    logic        req;
    fetch_addr_t req_pc;
    logic        word_valid;
    fetch_word_t word;
    logic        queue_full;

    fetch_pc pc_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .queue_full_i  (queue_full),
        .word_valid_i  (word_valid),
        .req_o         (req),
        .req_pc_o      (req_pc)
    );

    line_fetch line_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req),
        .req_pc_i      (req_pc),
        .word_valid_o  (word_valid),
        .word_o        (word),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    fetch_queue #(.DEPTH(`FETCH_QUEUE_DEPTH)) queue_i (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (redirect_i),               // drop wrong-path words
        .enq_i      (word_valid),
        .enq_word_i (word),
        .full_o     (queue_full),
        .deq_i      (inst_deq_i),
        .avail_o    (inst_avail_o),
        .head_o     (inst_o)
    );

endmodule : fetch_frontend

`default_nettype wire

//--- verilog/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   flush_i,

    input  logic                   enq_i,
    input  fetch_pkg::fetch_word_t enq_word_i,
    output logic                   full_o,

    input  logic                   deq_i,
    output logic                   avail_o,
    output fetch_pkg::fetch_word_t head_o
);

    import fetch_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_word_t mem_q [DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    logic do_enq;
    logic do_deq;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign avail_o = (count_q != '0);
    assign head_o  = mem_q[head_q];

    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_i && avail_o;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // wrap for any depth
    endfunction

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_enq) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (do_deq) begin
                head_q <= ptr_inc(head_q);
            end
            if (do_enq && !do_deq) begin
                count_q <= count_q + 1'b1;
            end else if (do_deq && !do_enq) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem_q[tail_q] <= enq_word_i;
        end
    end

endmodule : fetch_queue

`default_nettype wire

//--- verilog/line_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module line_fetch (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   req_i,
    input  fetch_pkg::fetch_addr_t req_pc_i,

    output logic                   word_valid_o,
    output fetch_pkg::fetch_word_t word_o,

    output fetch_pkg::fetch_addr_t bmem_addr_o,
    output logic                   bmem_read_o,
    input  logic                   bmem_ready_i,
    input  fetch_pkg::beat_t       bmem_rdata_i,
    input  logic                   bmem_rvalid_i
);

    import fetch_pkg::*;

    line_state_e state_q;
    line_state_e state_next;

    line_t                    line_q;
    tag_t                     tag_q;
    logic                     line_valid_q;
    tag_t                     fill_tag_q;       // line being refilled
    logic [BEAT_SEL_BITS-1:0] beat_cnt_q;

    tag_t                     req_tag;
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic                     hit;
    logic                     last_beat;

    assign req_tag  = req_pc_i[`FETCH_ADDR_WIDTH-1:OFFSET_BITS];
    assign word_sel = req_pc_i[OFFSET_BITS-1:INST_BYTE_BITS];
    assign hit      = line_valid_q && (tag_q == req_tag);

    assign last_beat = (beat_cnt_q == BEAT_SEL_BITS'(`FETCH_LINE_BEATS - 1));

    // hit answers in the same cycle
    assign word_valid_o = req_i && hit;
    assign word_o.pc    = req_pc_i;
    assign word_o.inst  = line_q[word_sel*`FETCH_INST_WIDTH +: `FETCH_INST_WIDTH];

    // one-cycle line-aligned read strobe
    assign bmem_read_o = (state_q == LINE_REQUEST) && bmem_ready_i;
    assign bmem_addr_o = {fill_tag_q, {OFFSET_BITS{1'b0}}};

    always_comb begin
        state_next = state_q;
        unique case (state_q)
            LINE_IDLE: begin
                if (req_i && !hit) begin
                    state_next = LINE_REQUEST;
                end
            end
            LINE_REQUEST: begin
                if (bmem_ready_i) begin
                    state_next = LINE_BURST;
                end
            end
            LINE_BURST: begin
                if (bmem_rvalid_i && last_beat) begin
                    state_next = LINE_IDLE;         // refill done
                end
            end
            default: begin
                state_next = LINE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= LINE_IDLE;
            line_valid_q <= 1'b0;
            beat_cnt_q   <= '0;
        end else begin
            state_q <= state_next;
            if (bmem_read_o) begin
                line_valid_q <= 1'b0;               // old line gets overwritten
                beat_cnt_q   <= '0;
            end else if (state_q == LINE_BURST && bmem_rvalid_i) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                if (last_beat) begin
                    line_valid_q <= 1'b1;
                end
            end
        end
    end

    // line data and tags
    always_ff @(posedge clk) begin
        if (state_q == LINE_IDLE && req_i && !hit) begin
            fill_tag_q <= req_tag;                  // latch miss address
        end
        if (state_q == LINE_BURST && bmem_rvalid_i) begin
            line_q[beat_cnt_q*`FETCH_BEAT_WIDTH +: `FETCH_BEAT_WIDTH] <= bmem_rdata_i;
            if (last_beat) begin
                tag_q <= fill_tag_q;
            end
        end
    end

endmodule : line_fetch

`default_nettype wire

//--- verilog/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_pc (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   redirect_i,
    input  fetch_pkg::fetch_addr_t redirect_pc_i,

    input  logic                   queue_full_i,
    input  logic                   word_valid_i,

    output logic                   req_o,
    output fetch_pkg::fetch_addr_t req_pc_o
);

    import fetch_pkg::*;

    fetch_addr_t pc_q;
    fetch_addr_t pc_next;

    // no request while the queue is full or a redirect is pending
    assign req_o    = !queue_full_i && !redirect_i;
    assign req_pc_o = pc_q;

    always_comb begin
        pc_next = pc_q;
        if (redirect_i) begin
            pc_next = redirect_pc_i;                // branch target wins
        end else if (word_valid_i) begin
            pc_next = pc_q + fetch_addr_t'(4);      // next sequential word
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule : fetch_pc

`default_nettype wire

//--- verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    `include "fetch_config.svh"

    localparam int LINE_WIDTH     = `FETCH_BEAT_WIDTH * `FETCH_LINE_BEATS;
    localparam int OFFSET_BITS    = $clog2(LINE_WIDTH / 8);         // byte offset in a line
    localparam int INST_BYTE_BITS = $clog2(`FETCH_INST_WIDTH / 8);  // byte offset in a word
    localparam int WORD_SEL_BITS  = OFFSET_BITS - INST_BYTE_BITS;
    localparam int BEAT_SEL_BITS  = $clog2(`FETCH_LINE_BEATS);

    typedef logic [`FETCH_ADDR_WIDTH-1:0] fetch_addr_t;
    typedef logic [`FETCH_INST_WIDTH-1:0] inst_t;
    typedef logic [`FETCH_BEAT_WIDTH-1:0] beat_t;
    typedef logic [LINE_WIDTH-1:0]        line_t;             // beat 0 in the low bits
    typedef logic [`FETCH_ADDR_WIDTH-OFFSET_BITS-1:0] tag_t;

    typedef struct packed {
        fetch_addr_t pc;
        inst_t       inst;
    } fetch_word_t;

    typedef enum logic [1:0] {
        LINE_IDLE,
        LINE_REQUEST,
        LINE_BURST
    } line_state_e;

endpackage : fetch_pkg

`default_nettype wire

//--- include/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// datapath widths
`define FETCH_ADDR_WIDTH 32
`define FETCH_INST_WIDTH 32
`define FETCH_BEAT_WIDTH 64

// 4 beats of 64 bits make one 256-bit line
`define FETCH_LINE_BEATS 4

// instruction queue
`define FETCH_QUEUE_DEPTH 16

// first fetch address out of reset
`define FETCH_RESET_PC 32'h1eceb000

`endif
